// ==== source/rsa_core_pkg.sv ====
package rsa_core_pkg;

	// ------------------------------------------------------------------
	// Arithmetic sizes
	// ------------------------------------------------------------------

	// Modulus, message, exponent and product all fit in one bus word.
	localparam int MOD_W = 32;

	// Fixed public exponent, F4.
	localparam logic [MOD_W-1:0] E_PUB = 32'd65537;

	// ------------------------------------------------------------------
	// Operation select
	// ------------------------------------------------------------------

	// Encrypt raises the message to E_PUB, decrypt raises it to the
	// private exponent supplied by the host.
	typedef enum logic {
		MODE_ENCRYPT = 1'b0,
		MODE_DECRYPT = 1'b1
	} rsa_mode_e;

endpackage

// ==== source/rsa_reg_pkg.sv ====
package rsa_reg_pkg;

	// ------------------------------------------------------------------
	// Register map
	// ------------------------------------------------------------------

	// Word address width of the register port.
	localparam int REG_ADDR_W = 3;

	// One entry per 32-bit word. START is a strobe and has no storage,
	// MSG_OUT and STATUS are read only.
	typedef enum logic [REG_ADDR_W-1:0] {
		REG_CTRL    = 3'd0,
		REG_P       = 3'd1,
		REG_Q       = 3'd2,
		REG_D       = 3'd3,
		REG_MSG_IN  = 3'd4,
		REG_START   = 3'd5,
		REG_MSG_OUT = 3'd6,
		REG_STATUS  = 3'd7
	} rsa_reg_e;

	// ------------------------------------------------------------------
	// STATUS fields
	// ------------------------------------------------------------------

	localparam int STAT_DONE_BIT = 0;
	localparam int STAT_BUSY_BIT = 1;

endpackage

// ==== source/rsa_modmul.sv ====
`timescale 1ns/1ps

module rsa_modmul
	import rsa_core_pkg::*;
(
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             mul_start_i,
	input  logic [MOD_W-1:0] a_i,
	input  logic [MOD_W-1:0] b_i,
	input  logic [MOD_W-1:0] n_i,
	output logic             mul_done_o,
	output logic [MOD_W-1:0] product_o
);

	localparam int CNT_W = $clog2(MOD_W);

	logic             run_q;
	logic [CNT_W-1:0] cnt_q;
	logic [MOD_W-1:0] a_q;
	logic [MOD_W-1:0] b_q;
	logic [MOD_W-1:0] n_q;
	logic [MOD_W-1:0] acc_q;

	logic [MOD_W-1:0] addend;
	logic [MOD_W:0]   dbl;
	logic [MOD_W:0]   dbl_red;
	logic [MOD_W:0]   sum;
	logic [MOD_W:0]   sum_red;

	// One bit of b per cycle, MSB first: acc = 2*acc + b[i]*a, each
	// stage pulled back below n by a single subtraction. This holds as
	// long as a < n.
	always_comb begin
		addend  = b_q[MOD_W-1] ? a_q : '0;
		dbl     = {acc_q, 1'b0};
		dbl_red = (dbl >= {1'b0, n_q}) ? dbl - {1'b0, n_q} : dbl;
		sum     = dbl_red + {1'b0, addend};
		sum_red = (sum >= {1'b0, n_q}) ? sum - {1'b0, n_q} : sum;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			run_q      <= 1'b0;
			cnt_q      <= '0;
			mul_done_o <= 1'b0;
		end else begin
			mul_done_o <= 1'b0;
			if (mul_start_i && !run_q) begin
				run_q <= 1'b1;
				cnt_q <= '0;
			end else if (run_q) begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == CNT_W'(MOD_W - 1)) begin
					run_q      <= 1'b0;
					mul_done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (mul_start_i && !run_q) begin
			a_q   <= a_i;
			b_q   <= b_i;
			n_q   <= n_i;
			acc_q <= '0;
		end else if (run_q) begin
			b_q   <= {b_q[MOD_W-2:0], 1'b0};
			acc_q <= sum_red[MOD_W-1:0];
		end
	end

	assign product_o = acc_q;

endmodule

// ==== source/rsa_modexp.sv ====
`timescale 1ns/1ps

module rsa_modexp
	import rsa_core_pkg::*;
#(
	parameter int PRIME_W = 16
) (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               start_i,
	input  rsa_mode_e          mode_i,
	input  logic [PRIME_W-1:0] p_i,
	input  logic [PRIME_W-1:0] q_i,
	input  logic [MOD_W-1:0]   d_i,
	input  logic [MOD_W-1:0]   msg_in_i,
	output logic               busy_o,
	output logic               done_o,
	output logic [MOD_W-1:0]   msg_out_o
);

	typedef enum logic [1:0] {
		IDLE,
		MUL_RESULT,
		MUL_SQUARE,
		FINISH
	} exp_state_e;

	exp_state_e       state_q;
	logic             issued_q;
	logic             reduce_q;
	logic [MOD_W-1:0] n_q;
	logic [MOD_W-1:0] exp_q;
	logic [MOD_W-1:0] base_q;
	logic [MOD_W-1:0] result_q;

	logic [MOD_W-1:0] n_w;
	logic [MOD_W-1:0] exp_w;
	logic [MOD_W-1:0] exp_shift;
	logic             exp_last;
	logic             mul_start;
	logic [MOD_W-1:0] mul_a;
	logic             mul_done;
	logic [MOD_W-1:0] product;

	assign n_w   = MOD_W'(p_i) * MOD_W'(q_i);
	assign exp_w = (mode_i == MODE_DECRYPT) ? d_i : E_PUB;

	assign exp_shift = exp_q >> 1;
	assign exp_last  = (exp_shift == '0);

	// The first square slot reduces the raw message: result still holds
	// 1 mod N there, so the product is msg mod N. Every later a operand
	// is then below N, as the multiplier needs.
	assign mul_a     = (state_q == MUL_SQUARE && !reduce_q) ? base_q : result_q;
	assign mul_start = (state_q == MUL_RESULT || state_q == MUL_SQUARE) && !issued_q;

	rsa_modmul u_rsa_modmul (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.mul_start_i (mul_start),
		.a_i         (mul_a),
		.b_i         (base_q),
		.n_i         (n_q),
		.mul_done_o  (mul_done),
		.product_o   (product)
	);

	// ------------------------------------------------------------------
	// Right-to-left square and multiply
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			issued_q  <= 1'b0;
			reduce_q  <= 1'b0;
			done_o    <= 1'b0;
			msg_out_o <= '0;
		end else begin
			if (mul_start) begin
				issued_q <= 1'b1;
			end
			if (mul_done) begin
				issued_q <= 1'b0;
			end

			case (state_q)
				IDLE: begin
					if (start_i) begin
						done_o   <= 1'b0;
						reduce_q <= 1'b1;
						state_q  <= (exp_w == '0) ? FINISH : MUL_SQUARE;
					end
				end
				MUL_SQUARE: begin
					if (mul_done) begin
						reduce_q <= 1'b0;
						// A clear bit only needs the next square.
						if (exp_q[0]) begin
							state_q <= MUL_RESULT;
						end else begin
							state_q <= MUL_SQUARE;
						end
					end
				end
				MUL_RESULT: begin
					if (mul_done) begin
						state_q <= exp_last ? FINISH : MUL_SQUARE;
					end
				end
				FINISH: begin
					msg_out_o <= result_q;
					done_o    <= 1'b1;
					state_q   <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && start_i) begin
			n_q      <= n_w;
			exp_q    <= exp_w;
			base_q   <= msg_in_i;
			result_q <= (n_w == MOD_W'(1)) ? '0 : MOD_W'(1);
		end else if (mul_done && state_q == MUL_SQUARE) begin
			base_q <= product;
			if (!exp_q[0]) begin
				exp_q <= exp_shift;
			end
		end else if (mul_done && state_q == MUL_RESULT) begin
			result_q <= product;
			exp_q    <= exp_shift;
		end
	end

	assign busy_o = (state_q != IDLE);

endmodule

// ==== source/rsa_reg_file.sv ====
`timescale 1ns/1ps

module rsa_reg_file
	import rsa_core_pkg::*;
	import rsa_reg_pkg::*;
#(
	parameter int PRIME_W = 16
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,

	// Wishbone classic slave.
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [REG_ADDR_W-1:0] wb_adr_i,
	input  logic [31:0]           wb_dat_i,
	output logic [31:0]           wb_dat_o,
	output logic                  wb_ack_o,

	input  logic                  lock_i,
	input  logic                  acct_en_i,

	// Core status and result.
	input  logic                  busy_i,
	input  logic                  done_i,
	input  logic [MOD_W-1:0]      msg_out_i,

	// Core operands and launch.
	output logic                  start_o,
	output rsa_mode_e             mode_o,
	output logic [PRIME_W-1:0]    p_o,
	output logic [PRIME_W-1:0]    q_o,
	output logic [MOD_W-1:0]      d_o,
	output logic [MOD_W-1:0]      msg_in_o
);

	logic        req;
	logic        wr_en;
	rsa_reg_e    reg_sel;
	logic [31:0] status_word;
	logic [31:0] rd_data;

	// A new request is one that has not been acknowledged yet. Since ack
	// lasts a single cycle, a held request is never counted twice.
	assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign reg_sel = rsa_reg_e'(wb_adr_i);

	// Writes land only when the port is enabled and unlocked.
	assign wr_en = req & wb_we_i & acct_en_i & ~lock_i;

	// ------------------------------------------------------------------
	// Bus handshake and launch strobe
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_ack_o <= 1'b0;
			start_o  <= 1'b0;
		end else begin
			wb_ack_o <= req;
			// A START while the core runs is acked and dropped.
			start_o  <= wr_en && (reg_sel == REG_START) && !busy_i;
		end
	end

	// ------------------------------------------------------------------
	// Operand registers
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			mode_o   <= MODE_ENCRYPT;
			p_o      <= '0;
			q_o      <= '0;
			d_o      <= '0;
			msg_in_o <= '0;
		end else if (wr_en) begin
			case (reg_sel)
				REG_CTRL:   mode_o   <= rsa_mode_e'(wb_dat_i[0]);
				REG_P:      p_o      <= wb_dat_i[PRIME_W-1:0];
				REG_Q:      q_o      <= wb_dat_i[PRIME_W-1:0];
				REG_D:      d_o      <= wb_dat_i;
				REG_MSG_IN: msg_in_o <= wb_dat_i;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------------

	always_comb begin
		status_word                = '0;
		status_word[STAT_DONE_BIT] = done_i;
		status_word[STAT_BUSY_BIT] = busy_i;

		rd_data = '0;
		if (acct_en_i) begin
			case (reg_sel)
				REG_CTRL:    rd_data = 32'(mode_o);
				REG_P:       rd_data = 32'(p_o);
				REG_Q:       rd_data = 32'(q_o);
				REG_D:       rd_data = d_o;
				REG_MSG_IN:  rd_data = msg_in_o;
				// Result and status are hidden while the lock is held.
				REG_MSG_OUT: rd_data = lock_i ? '0 : msg_out_i;
				REG_STATUS:  rd_data = lock_i ? '0 : status_word;
				default:     rd_data = '0;
			endcase
		end
	end

	// Read data is captured with the ack and is zero otherwise.
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_dat_o <= '0;
		end else if (req && !wb_we_i) begin
			wb_dat_o <= rd_data;
		end else begin
			wb_dat_o <= '0;
		end
	end

endmodule

// ==== source/rsa_accel.sv ====
`timescale 1ns/1ps

module rsa_accel
	import rsa_core_pkg::*;
	import rsa_reg_pkg::*;
#(
	parameter int PRIME_W = 16
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [REG_ADDR_W-1:0] wb_adr_i,
	input  logic [31:0]           wb_dat_i,
	output logic [31:0]           wb_dat_o,
	output logic                  wb_ack_o,
	input  logic                  lock_i,
	input  logic                  acct_en_i
);

	logic               start;
	rsa_mode_e          mode;
	logic [PRIME_W-1:0] p;
	logic [PRIME_W-1:0] q;
	logic [MOD_W-1:0]   d;
	logic [MOD_W-1:0]   msg_in;
	logic               busy;
	logic               done;
	logic [MOD_W-1:0]   msg_out;

	rsa_reg_file #(
		.PRIME_W (PRIME_W)
	) u_rsa_reg_file (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.lock_i    (lock_i),
		.acct_en_i (acct_en_i),
		.busy_i    (busy),
		.done_i    (done),
		.msg_out_i (msg_out),
		.start_o   (start),
		.mode_o    (mode),
		.p_o       (p),
		.q_o       (q),
		.d_o       (d),
		.msg_in_o  (msg_in)
	);

	rsa_modexp #(
		.PRIME_W (PRIME_W)
	) u_rsa_modexp (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.start_i   (start),
		.mode_i    (mode),
		.p_i       (p),
		.q_i       (q),
		.d_i       (d),
		.msg_in_i  (msg_in),
		.busy_o    (busy),
		.done_o    (done),
		.msg_out_o (msg_out)
	);

endmodule

// ==== dv/rsa_accel_sva.sv ====
`timescale 1ns/1ps

module rsa_accel_sva (
	input logic clk_i,
	input logic rst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i,
	input logic start_i,
	input logic busy_i,
	input logic done_i
);

	// ------------------------------------------------------------------
	// Wishbone handshake
	// ------------------------------------------------------------------

	ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wb_ack_o stayed high for more than one cycle");

	// Ack answers a request that was present on the previous edge.
	ack_after_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o rose without cyc and stb");

	// ------------------------------------------------------------------
	// Core status
	// ------------------------------------------------------------------

	busy_done_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(busy_i && done_i))
		else $error("busy and done are high together");

	done_clears_on_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$fell(done_i) |-> $past(start_i))
		else $error("done fell without a start pulse");

endmodule

bind rsa_accel rsa_accel_sva u_rsa_accel_sva (
	.clk_i    (clk_i),
	.rst_n_i  (rst_n_i),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_ack_i (wb_ack_o),
	.start_i  (start),
	.busy_i   (busy),
	.done_i   (done)
);

// ==== dv/rsa_accel_tb.sv ====
`timescale 1ns/1ps

module rsa_accel_tb
	import rsa_core_pkg::*;
	import rsa_reg_pkg::*;
();

	localparam int PRIME_W         = 16;
	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 16;
	// Six core runs plus the register-only phases.
	localparam int NUM_OPS         = 10;
	localparam int OP_CYCLES       = 2 * MOD_W * (MOD_W + 2) + 50;
	localparam int WATCHDOG_CYCLES = NUM_OPS * OP_CYCLES + RESET_CYCLES;
	localparam logic [31:0] PRIME_MASK = (32'd1 << PRIME_W) - 32'd1;

	logic                  clk_i;
	logic                  rst_n_i;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic                  wb_we_i;
	logic [REG_ADDR_W-1:0] wb_adr_i;
	logic [31:0]           wb_dat_i;
	logic [31:0]           wb_dat_o;
	logic                  wb_ack_o;
	logic                  lock_i;
	logic                  acct_en_i;
	integer                seed = 66050;

	rsa_accel #(
		.PRIME_W (PRIME_W)
	) u_rsa_accel (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.lock_i    (lock_i),
		.acct_en_i (acct_en_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	// ------------------------------------------------------------------
	// Checking and reference model
	// ------------------------------------------------------------------

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error: %s got 0x%08h, expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic is_prime(input logic [31:0] x);
		logic        prime;
		logic [31:0] i;
		prime = (x >= 2);
		i = 2;
		while (prime && i * i <= x) begin
			if (x % i == 0)
				prime = 1'b0;
			i++;
		end
		return prime;
	endfunction

	// Right-to-left square and multiply in 64 bits, so no product overflows.
	function automatic logic [31:0] ref_modexp(input logic [31:0] base,
			input logic [31:0] exp, input logic [31:0] n);
		logic [63:0] r, b, m;
		logic [31:0] e;
		m = {32'b0, n};
		r = 64'd1 % m;
		b = {32'b0, base} % m;
		e = exp;
		while (e != 0) begin
			if (e[0])
				r = (r * b) % m;
			b = (b * b) % m;
			e = e >> 1;
		end
		return r[31:0];
	endfunction

	task automatic random_prime(output logic [31:0] prime);
		logic [31:0] cand;
		cand = $random(seed);
		cand = 2 + cand % ((32'd1 << PRIME_W) - 2);
		while (!is_prime(cand))
			cand--;
		prime = cand;
	endtask

	// ------------------------------------------------------------------
	// Wishbone driver
	// ------------------------------------------------------------------

	task automatic wb_access(input logic we, input rsa_reg_e addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk_i);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= addr;
		wb_dat_i <= wdata;
		do begin
			@(negedge clk_i);
			waited++;
		end while (!wb_ack_o && waited < 4);
		// The slave sees the request on the next edge and acks one cycle later.
		assert (wb_ack_o && waited == 2) else begin
			$display("ack for the access to %s did not come one cycle after the request",
				addr.name());
			abort_run();
		end
		rdata = wb_dat_o;
		@(posedge clk_i);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic wb_write(input rsa_reg_e addr, input logic [31:0] data);
		logic [31:0] ignored;
		wb_access(1'b1, addr, data, ignored);
	endtask

	task automatic wb_read(input rsa_reg_e addr, output logic [31:0] data);
		wb_access(1'b0, addr, 32'h0, data);
	endtask

	task automatic read_expect(input rsa_reg_e addr, input logic [31:0] exp);
		logic [31:0] data;
		wb_read(addr, data);
		expect_value($sformatf("wb_dat_o (%s)", addr.name()), data, exp);
	endtask

	task automatic drive_lock(input logic value);
		@(posedge clk_i);
		lock_i <= value;
	endtask

	task automatic drive_access(input logic value);
		@(posedge clk_i);
		acct_en_i <= value;
	endtask

	task automatic wait_done();
		logic [31:0] status;
		int          polls;
		status = '0;
		polls = 0;
		while (!status[STAT_DONE_BIT] && polls < OP_CYCLES) begin
			wb_read(REG_STATUS, status);
			polls++;
		end
		assert (status[STAT_DONE_BIT]) else begin
			$display("the core did not report done within %0d status polls", OP_CYCLES);
			abort_run();
		end
		expect_value("wb_dat_o (REG_STATUS)", status, 32'h1);
	endtask

	// Loads the operands, launches the core and returns MSG_OUT. With
	// restart set, a second START is sent while the core is busy.
	task automatic run_op(input rsa_mode_e mode, input logic [31:0] p, input logic [31:0] q,
			input logic [31:0] d, input logic [31:0] msg, input logic restart,
			output logic [31:0] result);
		wb_write(REG_CTRL, {31'b0, mode});
		wb_write(REG_P, p);
		wb_write(REG_Q, q);
		wb_write(REG_D, d);
		wb_write(REG_MSG_IN, msg);
		wb_write(REG_START, 32'h0);
		if (restart) begin
			read_expect(REG_STATUS, 32'h2);
			// A changed message would show up in the result if the core restarted.
			wb_write(REG_MSG_IN, msg + 32'd1);
			wb_write(REG_START, 32'h0);
		end
		wait_done();
		wb_read(REG_MSG_OUT, result);
	endtask

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------

	initial begin
		logic [31:0] p, q, d, msg, res, cipher;
		int          i;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		lock_i    = 1'b0;
		acct_en_i = 1'b1;
		rst_n_i   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;

		for (i = 0; i < 8; i++)
			read_expect(rsa_reg_e'(i), 32'h0);

		p = $random(seed);
		q = $random(seed);
		d = $random(seed);
		msg = $random(seed);
		wb_write(REG_P, p);
		wb_write(REG_Q, q);
		wb_write(REG_D, d);
		wb_write(REG_MSG_IN, msg);
		wb_write(REG_CTRL, 32'h3);
		read_expect(REG_P, p & PRIME_MASK);
		read_expect(REG_Q, q & PRIME_MASK);
		read_expect(REG_D, d);
		read_expect(REG_MSG_IN, msg);
		read_expect(REG_CTRL, 32'h1);
		wb_write(REG_CTRL, 32'h0);
		read_expect(REG_CTRL, 32'h0);

		for (i = 0; i < 3; i++) begin
			random_prime(p);
			random_prime(q);
			msg = $random(seed);
			msg = msg % (p * q);
			run_op(MODE_ENCRYPT, p, q, 32'h0, msg, 1'b1, res);
			expect_value("MSG_OUT", res, ref_modexp(msg, E_PUB, p * q));
		end

		// 65537 is 17 mod phi(3233), so 2753 is its inverse.
		msg = $random(seed);
		msg = msg % 32'd3233;
		run_op(MODE_ENCRYPT, 32'd61, 32'd53, 32'd2753, msg, 1'b0, cipher);
		expect_value("MSG_OUT", cipher, ref_modexp(msg, E_PUB, 32'd3233));
		run_op(MODE_DECRYPT, 32'd61, 32'd53, 32'd2753, cipher, 1'b0, res);
		expect_value("MSG_OUT", res, msg);

		random_prime(p);
		random_prime(q);
		d = $random(seed);
		msg = $random(seed);
		msg = msg % (p * q);
		run_op(MODE_DECRYPT, p, q, d, msg, 1'b0, res);
		expect_value("MSG_OUT", res, ref_modexp(msg, d, p * q));

		drive_lock(1'b1);
		wb_write(REG_P, ~p);
		wb_write(REG_START, 32'h0);
		read_expect(REG_MSG_OUT, 32'h0);
		read_expect(REG_STATUS, 32'h0);
		read_expect(REG_P, p & PRIME_MASK);
		drive_lock(1'b0);
		read_expect(REG_P, p & PRIME_MASK);
		read_expect(REG_STATUS, 32'h1);
		read_expect(REG_MSG_OUT, res);

		drive_access(1'b0);
		wb_write(REG_P, ~p);
		wb_write(REG_START, 32'h0);
		for (i = 0; i < 8; i++)
			read_expect(rsa_reg_e'(i), 32'h0);
		drive_access(1'b1);
		read_expect(REG_P, p & PRIME_MASK);
		read_expect(REG_STATUS, 32'h1);
		read_expect(REG_MSG_OUT, res);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== rsa_accel.f ====
source/rsa_core_pkg.sv
source/rsa_reg_pkg.sv
source/rsa_modmul.sv
source/rsa_modexp.sv
source/rsa_reg_file.sv
source/rsa_accel.sv
dv/rsa_accel_sva.sv
dv/rsa_accel_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rsa_accel_tb
FILELIST  = rsa_accel.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
